// File: Makefile
TOOL       := verilator
FLAGS      := --binary --timing -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := decode_stage_tb
FILELIST   := sources.f
BUILD_DIR  := obj_dir
LOG        := sim.log

SOURCES := $(wildcard hw/*.sv hw/*.svh test/*.sv test/*.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/control.sv
`timescale 1ns/1ps
`default_nettype none

`include "dlx_cfg.svh"

module control (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 valid,
   input  dlx_isa_pkg::instr_t  instr,
   input  logic [`DLX_XLEN-1:0] pc_plus_four,
   input  logic                 take,
   input  logic [`DLX_XLEN-1:0] target,
   output dlx_ctrl_pkg::id_ex_t bundle
);
   import dlx_isa_pkg::*;
   import dlx_ctrl_pkg::*;

   instr_class_e cls;
   ctrl_word_t   dec;
   logic         kill; // Previous valid instruction was a load
   logic         squash;

   assign cls    = classify(instr);
   assign squash = kill | dec.illegal;

   always_comb begin
      dec        = '0;
      dec.alu_op = alu_pass;
      case (cls)
         cls_alu_r: begin
            dec.alu_src_reg = 1'b1;
            dec.reg_wr      = 1'b1;
            dec.reg_dst     = instr.rd;
            case (instr.func)
               func_add:  dec.alu_op = alu_add;
               func_addu: dec.alu_op = alu_addu;
               func_sub:  dec.alu_op = alu_sub;
               func_subu: dec.alu_op = alu_subu;
               func_and:  dec.alu_op = alu_and;
               func_or:   dec.alu_op = alu_or;
               func_xor:  dec.alu_op = alu_xor;
               func_slt:  dec.alu_op = alu_slt;
               func_sgt:  dec.alu_op = alu_sgt;
               default:   dec.alu_op = alu_pass;
            endcase
         end
         cls_alu_i: begin
            dec.reg_wr  = 1'b1;
            dec.reg_dst = instr.rs2;
            case (instr.opcode)
               op_addi: begin
                  dec.alu_op   = alu_add;
                  dec.ext_sign = 1'b1;
               end
               op_subi: begin
                  dec.alu_op   = alu_sub;
                  dec.ext_sign = 1'b1;
               end
               op_addui: dec.alu_op = alu_addu;
               default:  dec.alu_op = alu_subu; // subui
            endcase
         end
         cls_lhi: begin
            dec.alu_op  = alu_lhi;
            dec.reg_wr  = 1'b1;
            dec.reg_dst = instr.rs2;
         end
         cls_load: begin
            dec.alu_op       = alu_add; // Address = rs1 + imm
            dec.ext_sign     = 1'b1;
            dec.reg_wr       = 1'b1;
            dec.reg_dst      = instr.rs2;
            dec.mem_to_reg   = 1'b1;
            dec.mem_byte     = (instr.opcode != op_lw);
            dec.mem_unsigned = (instr.opcode == op_lbu);
         end
         cls_store: begin
            dec.alu_op   = alu_add;
            dec.ext_sign = 1'b1;
            dec.reg_dst  = instr.rs2;
            dec.mem_wr   = 1'b1;
            dec.mem_byte = (instr.opcode == op_sb);
         end
         cls_branch: begin
            dec.ext_sign = 1'b1;
            dec.reg_dst  = instr.rs2;
         end
         cls_jump: begin
            if (instr.opcode == op_jal) begin
               dec.reg_wr  = 1'b1;
               dec.reg_dst = `DLX_LINK_REG;
               dec.link    = 1'b1;
            end
         end
         cls_jr: dec.reg_dst = instr.rs2;
         default: dec.illegal = 1'b1;
      endcase
   end

   // Killed loads leave the load-use flag clear
   always_ff @(posedge clk) begin
      if (rst) begin
         kill <= 1'b0;
      end else if (valid) begin
         kill <= (cls == cls_load) & ~kill;
      end
   end

   always_comb begin
      bundle                 = '0;
      bundle.ctrl            = dec;
      bundle.ctrl.reg_wr     = dec.reg_wr & ~squash;
      bundle.ctrl.mem_wr     = dec.mem_wr & ~squash;
      bundle.ctrl.mem_to_reg = dec.mem_to_reg & ~squash;
      bundle.redirect        = take & ~squash;
      bundle.redirect_pc     = target;
      bundle.pc_plus_four    = pc_plus_four;
      bundle.imm             = instr[15:0];
   end

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "dlx_cfg.svh"

module decode_stage (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 in_valid,
   input  dlx_isa_pkg::if_id_t  in_bundle,
   output logic                 ex_valid,
   output dlx_ctrl_pkg::id_ex_t ex_bundle
);
   import dlx_isa_pkg::*;
   import dlx_ctrl_pkg::*;

   logic                 id_valid;
   if_id_t               id_data;
   logic                 take;
   logic [`DLX_XLEN-1:0] target;
   id_ex_t               id_bundle;

   pipe_reg #(
      .payload_t (if_id_t)
   ) if_id0 (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_data   (in_bundle),
      .out_valid (id_valid),
      .out_data  (id_data)
   );

   control control0 (
      .clk          (clk),
      .rst          (rst),
      .valid        (id_valid),
      .instr        (id_data.instr),
      .pc_plus_four (id_data.pc_plus_four),
      .take         (take),
      .target       (target),
      .bundle       (id_bundle)
   );

   jump_branch jump_branch0 (
      .instr        (id_data.instr),
      .pc_plus_four (id_data.pc_plus_four),
      .rs1_value    (id_data.rs1_value),
      .take         (take),
      .target       (target)
   );

   // Reset value carries the reset PC
   pipe_reg #(
      .payload_t (id_ex_t),
      .rst_value (id_ex_reset)
   ) id_ex0 (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (id_valid),
      .in_data   (id_bundle),
      .out_valid (ex_valid),
      .out_data  (ex_bundle)
   );

endmodule

`default_nettype wire

// File: hw/dlx_cfg.svh
`ifndef DLX_CFG_SVH
`define DLX_CFG_SVH

// Datapath and PC width
`define DLX_XLEN 32

`define DLX_RESET_PC 32'h0000_0000 // Held in the ID/EX bundle after reset

`define DLX_LINK_REG 5'd31 // jal return address register

`endif

// File: hw/dlx_ctrl_pkg.sv
`default_nettype none

`include "dlx_cfg.svh"

package dlx_ctrl_pkg;

   typedef enum logic [3:0] {
      alu_and  = 4'b0000,
      alu_or   = 4'b0001,
      alu_addu = 4'b0010,
      alu_add  = 4'b0011,
      alu_sub  = 4'b0100,
      alu_slt  = 4'b0101,
      alu_xor  = 4'b0110,
      alu_subu = 4'b0111,
      alu_sgt  = 4'b1000,
      alu_lhi  = 4'b1001, // Immediate shifted up by 16
      alu_pass = 4'b1111
   } alu_op_e;

   typedef struct packed {
      alu_op_e    alu_op;
      logic       alu_src_reg; // 0 selects the immediate
      logic       ext_sign;
      logic       reg_wr;
      logic [4:0] reg_dst;
      logic       mem_wr;
      logic       mem_to_reg;
      logic       mem_byte;
      logic       mem_unsigned;
      logic       link; // Write back pc_plus_four
      logic       illegal;
   } ctrl_word_t;

   typedef struct packed {
      ctrl_word_t           ctrl;
      logic                 redirect;
      logic [`DLX_XLEN-1:0] redirect_pc;
      logic [`DLX_XLEN-1:0] pc_plus_four;
      logic [15:0]          imm;
   } id_ex_t;

   localparam id_ex_t id_ex_reset = '{
      ctrl:         '0,
      redirect:     1'b0,
      redirect_pc:  `DLX_RESET_PC,
      pc_plus_four: `DLX_RESET_PC,
      imm:          '0
   };

endpackage

`default_nettype wire

// File: hw/dlx_isa_pkg.sv
`default_nettype none

`include "dlx_cfg.svh"

package dlx_isa_pkg;

   typedef struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rs1;
      logic [4:0]  rs2; // Destination for I-type
      logic [4:0]  rd;
      logic [10:0] func;
   } instr_t;

   typedef struct packed {
      instr_t               instr;
      logic [`DLX_XLEN-1:0] pc_plus_four;
      logic [`DLX_XLEN-1:0] rs1_value;
   } if_id_t;

   localparam logic [5:0] op_special = 6'h00;
   localparam logic [5:0] op_j       = 6'h02;
   localparam logic [5:0] op_jal     = 6'h03;
   localparam logic [5:0] op_beqz    = 6'h04;
   localparam logic [5:0] op_bnez    = 6'h05;
   localparam logic [5:0] op_addi    = 6'h08;
   localparam logic [5:0] op_addui   = 6'h09;
   localparam logic [5:0] op_subi    = 6'h0a;
   localparam logic [5:0] op_subui   = 6'h0b;
   localparam logic [5:0] op_lhi     = 6'h0f;
   localparam logic [5:0] op_jr      = 6'h12;
   localparam logic [5:0] op_lb      = 6'h20;
   localparam logic [5:0] op_lw      = 6'h23;
   localparam logic [5:0] op_lbu     = 6'h24;
   localparam logic [5:0] op_sb      = 6'h28;
   localparam logic [5:0] op_sw      = 6'h2b;

   localparam logic [10:0] func_add  = 11'h020;
   localparam logic [10:0] func_addu = 11'h021;
   localparam logic [10:0] func_sub  = 11'h022;
   localparam logic [10:0] func_subu = 11'h023;
   localparam logic [10:0] func_and  = 11'h024;
   localparam logic [10:0] func_or   = 11'h025;
   localparam logic [10:0] func_xor  = 11'h026;
   localparam logic [10:0] func_slt  = 11'h02a;
   localparam logic [10:0] func_sgt  = 11'h02b;

   typedef enum logic [3:0] {
      cls_alu_r,
      cls_alu_i,
      cls_lhi,
      cls_load,
      cls_store,
      cls_branch,
      cls_jump, // j and jal
      cls_jr,
      cls_illegal
   } instr_class_e;

   function automatic instr_class_e classify(instr_t i);
      instr_class_e c;
      c = cls_illegal;
      case (i.opcode)
         op_special: begin
            case (i.func)
               func_add, func_addu, func_sub, func_subu, func_and,
               func_or, func_xor, func_slt, func_sgt: c = cls_alu_r;
               default: c = cls_illegal;
            endcase
         end
         op_addi, op_addui, op_subi, op_subui: c = cls_alu_i;
         op_lhi: c = cls_lhi;
         op_lb, op_lw, op_lbu: c = cls_load;
         op_sb, op_sw: c = cls_store;
         op_beqz, op_bnez: c = cls_branch;
         op_j, op_jal: c = cls_jump;
         op_jr: c = cls_jr;
         default: c = cls_illegal;
      endcase
      return c;
   endfunction

endpackage

`default_nettype wire

// File: hw/jump_branch.sv
`timescale 1ns/1ps
`default_nettype none

`include "dlx_cfg.svh"

module jump_branch (
   input  dlx_isa_pkg::instr_t  instr,
   input  logic [`DLX_XLEN-1:0] pc_plus_four,
   input  logic [`DLX_XLEN-1:0] rs1_value,
   output logic                 take,
   output logic [`DLX_XLEN-1:0] target
);
   import dlx_isa_pkg::*;

   logic [`DLX_XLEN-1:0] imm_ext;
   logic [`DLX_XLEN-1:0] off_ext;
   logic                 rs1_zero;

   assign imm_ext  = {{(`DLX_XLEN-16){instr[15]}}, instr[15:0]};
   assign off_ext  = {{(`DLX_XLEN-26){instr[25]}}, instr[25:0]};
   assign rs1_zero = (rs1_value == '0);

   always_comb begin
      take   = 1'b0;
      target = pc_plus_four; // Fall through
      case (instr.opcode)
         op_beqz: begin
            take   = rs1_zero;
            target = pc_plus_four + imm_ext;
         end
         op_bnez: begin
            take   = ~rs1_zero;
            target = pc_plus_four + imm_ext;
         end
         op_j, op_jal: begin
            take   = 1'b1;
            target = pc_plus_four + off_ext;
         end
         op_jr: begin
            take   = 1'b1;
            target = rs1_value;
         end
         default: begin
            take   = 1'b0;
            target = pc_plus_four;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: hw/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
   parameter type      payload_t = logic,
   parameter payload_t rst_value = '0
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     in_valid,
   input  payload_t in_data,
   output logic     out_valid,
   output payload_t out_data
);

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
         out_data  <= rst_value;
      end else begin
         out_valid <= in_valid; // Bubble when in_valid is low
         if (in_valid) begin
            out_data <= in_data;
         end
      end
   end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hw
+incdir+test
hw/dlx_isa_pkg.sv
hw/dlx_ctrl_pkg.sv
hw/pipe_reg.sv
hw/jump_branch.sv
hw/control.sv
hw/decode_stage.sv
test/decode_stage_tb.sv

// File: test/decode_ref.svh
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

function automatic bit is_load_op(logic [5:0] op);
   return (op == op_lw) || (op == op_lb) || (op == op_lbu);
endfunction

// Expected ID/EX bundle for one instruction
function automatic id_ex_t decode_expect(if_id_t b, bit killed);
   id_ex_t               e;
   instr_t               i;
   logic [`DLX_XLEN-1:0] imm_s;
   logic [`DLX_XLEN-1:0] off_s;
   logic                 take;
   i     = b.instr;
   imm_s = {{(`DLX_XLEN-16){i[15]}}, i[15:0]};
   off_s = {{(`DLX_XLEN-26){i[25]}}, i[25:0]};
   take  = 1'b0;
   e                = '0;
   e.ctrl.alu_op    = alu_pass;
   e.pc_plus_four   = b.pc_plus_four;
   e.redirect_pc    = b.pc_plus_four; // Fall through unless a jump or branch
   e.imm            = i[15:0];
   case (i.opcode)
      op_special: begin
         e.ctrl.alu_src_reg = 1'b1;
         e.ctrl.reg_wr      = 1'b1;
         e.ctrl.reg_dst     = i.rd;
         case (i.func)
            func_add:  e.ctrl.alu_op = alu_add;
            func_addu: e.ctrl.alu_op = alu_addu;
            func_sub:  e.ctrl.alu_op = alu_sub;
            func_subu: e.ctrl.alu_op = alu_subu;
            func_and:  e.ctrl.alu_op = alu_and;
            func_or:   e.ctrl.alu_op = alu_or;
            func_xor:  e.ctrl.alu_op = alu_xor;
            func_slt:  e.ctrl.alu_op = alu_slt;
            func_sgt:  e.ctrl.alu_op = alu_sgt;
            default: begin
               e.ctrl         = '0; // Unknown func
               e.ctrl.alu_op  = alu_pass;
               e.ctrl.illegal = 1'b1;
            end
         endcase
      end
      op_addi, op_addui, op_subi, op_subui: begin
         e.ctrl.reg_wr   = 1'b1;
         e.ctrl.reg_dst  = i.rs2;
         e.ctrl.ext_sign = (i.opcode == op_addi) || (i.opcode == op_subi);
         if (i.opcode == op_addi) e.ctrl.alu_op = alu_add;
         else if (i.opcode == op_subi) e.ctrl.alu_op = alu_sub;
         else if (i.opcode == op_addui) e.ctrl.alu_op = alu_addu;
         else e.ctrl.alu_op = alu_subu;
      end
      op_lhi: begin
         e.ctrl.alu_op  = alu_lhi;
         e.ctrl.reg_wr  = 1'b1;
         e.ctrl.reg_dst = i.rs2;
      end
      op_lw, op_lb, op_lbu: begin
         e.ctrl.alu_op       = alu_add;
         e.ctrl.ext_sign     = 1'b1;
         e.ctrl.reg_wr       = 1'b1;
         e.ctrl.reg_dst      = i.rs2;
         e.ctrl.mem_to_reg   = 1'b1;
         e.ctrl.mem_byte     = (i.opcode != op_lw);
         e.ctrl.mem_unsigned = (i.opcode == op_lbu);
      end
      op_sw, op_sb: begin
         e.ctrl.alu_op   = alu_add;
         e.ctrl.ext_sign = 1'b1;
         e.ctrl.reg_dst  = i.rs2;
         e.ctrl.mem_wr   = 1'b1;
         e.ctrl.mem_byte = (i.opcode == op_sb);
      end
      op_beqz, op_bnez: begin
         e.ctrl.ext_sign = 1'b1;
         e.ctrl.reg_dst  = i.rs2;
         e.redirect_pc   = b.pc_plus_four + imm_s;
         take = ((b.rs1_value == '0) == (i.opcode == op_beqz));
      end
      op_j, op_jal: begin
         e.redirect_pc = b.pc_plus_four + off_s;
         take          = 1'b1;
         if (i.opcode == op_jal) begin
            e.ctrl.reg_wr  = 1'b1;
            e.ctrl.reg_dst = `DLX_LINK_REG;
            e.ctrl.link    = 1'b1;
         end
      end
      op_jr: begin
         e.ctrl.reg_dst = i.rs2;
         e.redirect_pc  = b.rs1_value;
         take           = 1'b1;
      end
      default: e.ctrl.illegal = 1'b1;
   endcase
   if (killed || e.ctrl.illegal) begin // Side effects dropped
      e.ctrl.reg_wr     = 1'b0;
      e.ctrl.mem_wr     = 1'b0;
      e.ctrl.mem_to_reg = 1'b0;
      take              = 1'b0;
   end
   e.redirect = take;
   return e;
endfunction

`endif

// File: test/decode_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dlx_cfg.svh"

module decode_stage_tb;
   import dlx_isa_pkg::*;
   import dlx_ctrl_pkg::*;

   `include "decode_ref.svh"

   logic   clk;
   logic   rst;
   logic   in_valid;
   if_id_t in_bundle;
   logic   ex_valid;
   id_ex_t ex_bundle;

   int          seed = 18610;
   int          cyc = 0;
   int          errors = 0;
   int          checked = 0;
   bit          kill_state = 1'b0; // Testbench copy of the load-use flag
   logic [5:0]  legal_ops [15];
   logic [10:0] legal_funcs [9];

   // Pending inputs in arrival order
   if_id_t in_q[$];
   bit     kill_q[$];
   int     due_q[$];
   string  name_q[$];

   decode_stage dut0 (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_bundle (in_bundle),
      .ex_valid  (ex_valid),
      .ex_bundle (ex_bundle)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   task automatic report_fail(input string test, input string field,
                              input logic [31:0] exp, input logic [31:0] act);
      errors++;
      $display("FAILED %s %s expected %h actual %h", test, field, exp, act);
   endtask

   task automatic check_reset_state();
      if (ex_valid !== 1'b0) report_fail("reset", "ex_valid", 32'd0, 32'(ex_valid));
      if (ex_bundle.ctrl !== '0) report_fail("reset", "ctrl", 32'd0, 32'(ex_bundle.ctrl));
      if (ex_bundle.redirect !== 1'b0) begin
         report_fail("reset", "redirect", 32'd0, 32'(ex_bundle.redirect));
      end
   endtask

   task automatic drive(input instr_t ins, input logic [31:0] rs1v, input string name);
      if_id_t b;
      b.instr        = ins;
      b.pc_plus_four = $random(seed) & 32'hffff_fffc;
      b.rs1_value    = rs1v;
      in_valid       = 1'b1;
      in_bundle      = b;
      in_q.push_back(b);
      kill_q.push_back(kill_state);
      due_q.push_back(cyc + 2); // Seen two falling edges later
      name_q.push_back(name);
      kill_state = is_load_op(ins.opcode) && !kill_state;
      @(negedge clk);
   endtask

   task automatic drive_op(input logic [5:0] op, input logic [10:0] func,
                           input logic [31:0] rs1v, input string name);
      instr_t ins;
      ins        = $random(seed);
      ins.opcode = op;
      if (op == op_special) ins.func = func;
      drive(ins, rs1v, name);
   endtask

   task automatic idle(input int n);
      in_valid = 1'b0;
      repeat (n) @(negedge clk);
   endtask

   task automatic finish_run();
      $display("%0d outputs checked, %0d errors", checked, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   endtask

   // Outputs change on the rising edge and are compared on the falling edge
   initial begin : compare
      if_id_t b;
      id_ex_t e;
      bit     k;
      int     due;
      string  nm;
      forever begin
         @(negedge clk);
         if (!rst && ex_valid === 1'b1) begin
            if (in_q.size() == 0) begin
               errors++;
               $display("Output appeared at cycle %0d with no pending input", cyc);
            end else begin
               b   = in_q.pop_front();
               k   = kill_q.pop_front();
               due = due_q.pop_front();
               nm  = name_q.pop_front();
               e   = decode_expect(b, k);
               checked++;
               if (cyc != due) report_fail(nm, "cycle", due, cyc);
               if (ex_bundle.ctrl !== e.ctrl) begin
                  report_fail(nm, "ctrl", 32'(e.ctrl), 32'(ex_bundle.ctrl));
               end
               if (ex_bundle.redirect !== e.redirect) begin
                  report_fail(nm, "redirect", 32'(e.redirect), 32'(ex_bundle.redirect));
               end
               if (ex_bundle.redirect_pc !== e.redirect_pc) begin
                  report_fail(nm, "redirect_pc", e.redirect_pc, ex_bundle.redirect_pc);
               end
               if (ex_bundle.pc_plus_four !== e.pc_plus_four) begin
                  report_fail(nm, "pc_plus_four", e.pc_plus_four, ex_bundle.pc_plus_four);
               end
               if (ex_bundle.imm !== e.imm) begin
                  report_fail(nm, "imm", 32'(e.imm), 32'(ex_bundle.imm));
               end
            end
         end
      end
   end

   initial begin : stimulus
      instr_t      ins;
      logic [31:0] rs1v;
      int          n;
      int          sel;
      int          waited;
      legal_ops   = '{op_addi, op_addui, op_subi, op_subui, op_lhi, op_lw, op_lb, op_lbu,
                      op_sw, op_sb, op_beqz, op_bnez, op_jr, op_j, op_jal};
      legal_funcs = '{func_add, func_addu, func_sub, func_subu, func_and, func_or,
                      func_xor, func_slt, func_sgt};
      rst       = 1'b1;
      in_valid  = 1'b0;
      in_bundle = '0;
      for (n = 0; n < 10; n++) begin
         @(negedge clk);
         check_reset_state();
      end
      rst = 1'b0;
      @(negedge clk);
      check_reset_state();

      for (n = 0; n < 9; n++) begin
         drive_op(op_special, legal_funcs[n[3:0]], $random(seed), "decode_r");
      end
      drive_op(op_special, 11'h000, $random(seed), "decode_bad_func");
      drive_op(op_special, 11'h7ff, $random(seed), "decode_bad_func");
      for (n = 0; n < 15; n++) begin
         drive_op(legal_ops[n[3:0]], 11'h0, $random(seed), "decode_op");
      end
      drive_op(6'h01, 11'h0, $random(seed), "decode_bad_op");
      drive_op(6'h3f, 11'h0, $random(seed), "decode_bad_op");
      idle(2);

      for (n = 0; n < 8; n++) begin
         rs1v = n[0] ? ($random(seed) | 32'h1) : 32'd0;
         drive_op(n[1] ? op_bnez : op_beqz, 11'h0, rs1v, "branch");
         ins        = $random(seed);
         ins.opcode = n[2] ? op_jal : op_j;
         ins[25]    = n[0]; // Backward offset on odd passes
         drive(ins, rs1v, "jump");
         drive_op(op_jr, 11'h0, $random(seed), "jump_reg");
      end
      idle(1);

      drive_op(op_lw, 11'h0, $random(seed), "kill_next");
      drive_op(op_special, func_add, $random(seed), "kill_next");
      drive_op(op_lw, 11'h0, $random(seed), "kill_gap");
      idle(3);
      drive_op(op_jal, 11'h0, $random(seed), "kill_gap");
      drive_op(op_lb, 11'h0, $random(seed), "kill_load_load");
      drive_op(op_lbu, 11'h0, $random(seed), "kill_load_load");
      drive_op(op_sw, 11'h0, $random(seed), "kill_load_load");
      drive_op(op_lw, 11'h0, $random(seed), "kill_branch");
      drive_op(op_beqz, 11'h0, 32'd0, "kill_branch");
      drive_op(op_special, func_or, $random(seed), "kill_branch");
      idle(2);

      for (n = 0; n < 200; n++) begin
         sel = {$random(seed)} % 20;
         if (sel < 15) begin
            drive_op(legal_ops[sel[3:0]], 11'h0, $random(seed), "burst");
         end else if (sel < 18) begin
            sel = {$random(seed)} % 9;
            drive_op(op_special, legal_funcs[sel[3:0]], $random(seed), "burst");
         end else begin
            ins = $random(seed); // Any encoding including illegal ones
            drive(ins, $random(seed), "burst");
         end
         if ({$random(seed)} % 4 == 0) idle(1 + {$random(seed)} % 3);
      end
      in_valid = 1'b0;

      waited = 0;
      while (in_q.size() != 0 && waited < 50) begin
         @(negedge clk);
         waited++;
      end
      if (in_q.size() != 0) begin
         errors++;
         $display("Timeout: no output after valid input, %0d items missing", in_q.size());
      end
      finish_run();
   end

endmodule

`default_nettype wire
